//--- include/gpu_config.svh
// Device configuration for the GPU reduction top level
// Cluster count, memory and DCR widths, FIFO depth and DCR map
`ifndef GPU_CONFIG_SVH
`define GPU_CONFIG_SVH

// Number of compute clusters
`define NUM_CLUSTERS        4

// External memory port
`define MEM_ADDR_WIDTH      16
`define MEM_DATA_WIDTH      32
`define MEM_BYTEEN_WIDTH    4
// Low bits carry the cluster index, top bits the request kind
`define MEM_TAG_WIDTH       4

// Request FIFO toward the memory port
`define MEM_FIFO_DEPTH      4

// DCR bus
`define DCR_ADDR_WIDTH      4
`define DCR_DATA_WIDTH      32

// DCR address map
`define DCR_BASE_ADDR       4'd0
`define DCR_COUNT           4'd1
`define DCR_RESULT_ADDR     4'd2
`define DCR_STRIDE          4'd3
`define DCR_START           4'd4

`endif

//--- hdl/gpu_pkg.sv
// Shared types for the GPU device
// Memory request and response, DCR write and captured configuration
`include "gpu_config.svh"

package gpu_pkg;

    // One request on the memory port
    typedef struct packed {
        logic                           rw;
        logic [`MEM_BYTEEN_WIDTH-1:0]   byteen;
        logic [`MEM_ADDR_WIDTH-1:0]     addr;
        logic [`MEM_DATA_WIDTH-1:0]     data;
        logic [`MEM_TAG_WIDTH-1:0]      tag;
    } mem_req_t;

    // Read data returned with the request tag
    typedef struct packed {
        logic [`MEM_DATA_WIDTH-1:0]     data;
        logic [`MEM_TAG_WIDTH-1:0]      tag;
    } mem_rsp_t;

    // Host DCR write
    typedef struct packed {
        logic [`DCR_ADDR_WIDTH-1:0]     addr;
        logic [`DCR_DATA_WIDTH-1:0]     data;
    } dcr_wr_t;

    // Reduction setup shared by all clusters
    typedef struct packed {
        logic [`MEM_ADDR_WIDTH-1:0]     base;
        logic [`MEM_ADDR_WIDTH-1:0]     count;
        logic [`MEM_ADDR_WIDTH-1:0]     result_addr;
        logic [`MEM_ADDR_WIDTH-1:0]     stride;
    } dcr_cfg_t;

endpackage

//--- hdl/dcr_regs.sv
// DCR register block
// Captures host writes into the configuration and raises the start pulse
`include "gpu_config.svh"

module dcr_regs import gpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,

    // Host write strobe
    input  logic        dcr_wr_valid,
    input  dcr_wr_t     dcr_wr,

    // To the clusters
    output dcr_cfg_t    cfg,
    output logic        start
);

    logic [`MEM_ADDR_WIDTH-1:0] wr_value;

    // Configuration fields are address sized
    assign wr_value = dcr_wr.data[`MEM_ADDR_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg <= '0;
        end else if (dcr_wr_valid) begin
            case (dcr_wr.addr)
                `DCR_BASE_ADDR: begin
                    cfg.base <= wr_value;
                end
                `DCR_COUNT: begin
                    cfg.count <= wr_value;
                end
                `DCR_RESULT_ADDR: begin
                    cfg.result_addr <= wr_value;
                end
                `DCR_STRIDE: begin
                    cfg.stride <= wr_value;
                end
                default: begin
                    // Start and unmapped addresses leave the config alone
                end
            endcase
        end
    end

    // One cycle pulse, data value is don't care
    always_ff @(posedge clk) begin
        if (reset) begin
            start <= 1'b0;
        end else begin
            start <= dcr_wr_valid && (dcr_wr.addr == `DCR_START);
        end
    end

endmodule

//--- hdl/compute_cluster.sv
// Compute cluster reduction engine
// Reads a block of words, sums the responses and writes the sum back
`include "gpu_config.svh"

module compute_cluster import gpu_pkg::*; #(
    parameter int CLUSTER_ID = 0
) (
    input  logic        clk,
    input  logic        reset,

    input  dcr_cfg_t    cfg,
    input  logic        start,

    // Request side toward the arbiter
    output logic        req_valid,
    output mem_req_t    req,
    input  logic        req_ready,

    // Responses routed back by tag
    input  logic        rsp_valid,
    input  mem_rsp_t    rsp,

    output logic        busy
);

    localparam int ID_BITS   = $clog2(`NUM_CLUSTERS);
    localparam int KIND_BITS = `MEM_TAG_WIDTH - ID_BITS;

    // Request kind in the top tag bits
    localparam logic [KIND_BITS-1:0] KIND_RD = KIND_BITS'(1);
    localparam logic [KIND_BITS-1:0] KIND_WR = KIND_BITS'(2);

    typedef enum logic [1:0] {
        S_IDLE,
        S_READ,
        S_WRITE
    } state_t;

    state_t                         state;
    logic [`MEM_ADDR_WIDTH-1:0]     rd_addr;
    logic [`MEM_ADDR_WIDTH-1:0]     wr_addr;
    logic [`MEM_ADDR_WIDTH-1:0]     reads_left;
    logic [`MEM_ADDR_WIDTH-1:0]     rsps_left;
    logic [`MEM_DATA_WIDTH-1:0]     sum;
    logic                           req_fire;
    logic                           launch;

    assign req_fire = req_valid && req_ready;
    assign launch   = (state == S_IDLE) && start;
    assign busy     = (state != S_IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:  if (start) state <= S_READ;
                S_READ:  if (rsps_left == '0) state <= S_WRITE;
                S_WRITE: if (req_fire) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // Reads and responses are counted separately, several reads in flight
    always_ff @(posedge clk) begin
        if (reset) begin
            reads_left <= '0;
            rsps_left  <= '0;
        end else if (launch) begin
            reads_left <= cfg.count;
            rsps_left  <= cfg.count;
        end else if (state == S_READ) begin
            if (req_fire) reads_left <= reads_left - 1'b1;
            if (rsp_valid) rsps_left <= rsps_left - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            rd_addr <= cfg.base + cfg.stride * `MEM_ADDR_WIDTH'(CLUSTER_ID);
            wr_addr <= cfg.result_addr + `MEM_ADDR_WIDTH'(CLUSTER_ID);
            sum     <= '0;
        end else if (state == S_READ) begin
            if (req_fire) rd_addr <= rd_addr + 1'b1;
            if (rsp_valid) sum <= sum + rsp.data;
        end
    end

    // Cluster index bits are filled in by the arbiter
    always_comb begin
        req       = '0;
        req_valid = 1'b0;
        case (state)
            S_READ: begin
                req_valid = (reads_left != '0);
                req.addr  = rd_addr;
                req.tag   = {KIND_RD, {ID_BITS{1'b0}}};
            end
            S_WRITE: begin
                req_valid  = 1'b1;
                req.rw     = 1'b1;
                req.byteen = '1;
                req.addr   = wr_addr;
                req.data   = sum;
                req.tag    = {KIND_WR, {ID_BITS{1'b0}}};
            end
            default: begin
            end
        endcase
    end

endmodule

//--- hdl/mem_arbiter.sv
// Round-robin memory request arbiter
// Merges cluster requests with an index tag and routes responses back by tag
`include "gpu_config.svh"

module mem_arbiter import gpu_pkg::*; (
    input  logic                            clk,
    input  logic                            reset,

    // Cluster requests
    input  logic [`NUM_CLUSTERS-1:0]        in_valid,
    input  mem_req_t [`NUM_CLUSTERS-1:0]    in_req,
    output logic [`NUM_CLUSTERS-1:0]        in_ready,

    // Merged request toward the FIFO
    output logic                            out_valid,
    output mem_req_t                        out_req,
    input  logic                            out_ready,

    // Memory responses
    input  logic                            mem_rsp_valid,
    input  mem_rsp_t                        mem_rsp,
    output logic [`NUM_CLUSTERS-1:0]        rsp_valid,
    output mem_rsp_t                        rsp
);

    localparam int ID_BITS = $clog2(`NUM_CLUSTERS);

    logic [ID_BITS-1:0] rr_ptr;
    logic [ID_BITS-1:0] pick;
    logic [ID_BITS-1:0] grant;
    logic [ID_BITS-1:0] grant_q;
    logic               locked;
    logic               found;
    logic               out_fire;

    // First valid requester at or after the pointer
    always_comb begin
        int idx;
        found = 1'b0;
        pick  = rr_ptr;
        for (int i = 0; i < `NUM_CLUSTERS; i++) begin
            idx = (int'(rr_ptr) + i) % `NUM_CLUSTERS;
            if (!found && in_valid[idx]) begin
                found = 1'b1;
                pick  = ID_BITS'(idx);
            end
        end
    end

    // A stalled grant is held until it transfers
    assign grant    = locked ? grant_q : pick;
    assign out_fire = out_valid && out_ready;

    assign out_valid = in_valid[grant];

    always_comb begin
        out_req = in_req[grant];
        out_req.tag[ID_BITS-1:0] = grant;
    end

    always_comb begin
        in_ready = '0;
        in_ready[grant] = out_ready;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rr_ptr <= '0;
            locked <= 1'b0;
        end else if (out_fire) begin
            rr_ptr <= ID_BITS'((int'(grant) + 1) % `NUM_CLUSTERS);
            locked <= 1'b0;
        end else if (out_valid) begin
            locked <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        grant_q <= grant;
    end

    // Response valid demux on the cluster index bits
    assign rsp = mem_rsp;

    always_comb begin
        rsp_valid = '0;
        rsp_valid[mem_rsp.tag[ID_BITS-1:0]] = mem_rsp_valid;
    end

endmodule

//--- hdl/mem_req_fifo.sv
// Memory request FIFO
// Registered circular buffer between the arbiter and the memory port
`include "gpu_config.svh"

module mem_req_fifo import gpu_pkg::*; #(
    parameter int DEPTH = `MEM_FIFO_DEPTH
) (
    input  logic        clk,
    input  logic        reset,

    input  logic        in_valid,
    input  mem_req_t    in_req,
    output logic        in_ready,

    output logic        out_valid,
    output mem_req_t    out_req,
    input  logic        out_ready,

    output logic        empty
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    mem_req_t               entries [DEPTH];
    logic [PTR_BITS-1:0]    wr_ptr;
    logic [PTR_BITS-1:0]    rd_ptr;
    logic [CNT_BITS-1:0]    count;
    logic                   push;
    logic                   pop;

    assign in_ready  = (count != CNT_BITS'(DEPTH));
    assign empty     = (count == '0);
    assign out_valid = !empty;
    assign out_req   = entries[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) entries[wr_ptr] <= in_req;
    end

    // Pointers wrap at DEPTH, count tracks occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop) rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- hdl/gpu_device.sv
// GPU device top level
// DCR block, reduction clusters, request arbiter and FIFO to one memory port
`include "gpu_config.svh"

module gpu_device import gpu_pkg::*; (
    input  logic        clk,
    input  logic        reset,

    // Memory request
    output logic        mem_req_valid,
    output mem_req_t    mem_req,
    input  logic        mem_req_ready,

    // Memory response
    input  logic        mem_rsp_valid,
    input  mem_rsp_t    mem_rsp,
    output logic        mem_rsp_ready,

    // DCR write
    input  logic        dcr_wr_valid,
    input  dcr_wr_t     dcr_wr,

    output logic        busy
);

    dcr_cfg_t                           cfg;
    logic                               start;

    logic [`NUM_CLUSTERS-1:0]           cluster_req_valid;
    mem_req_t [`NUM_CLUSTERS-1:0]       cluster_req;
    logic [`NUM_CLUSTERS-1:0]           cluster_req_ready;
    logic [`NUM_CLUSTERS-1:0]           cluster_rsp_valid;
    mem_rsp_t                           cluster_rsp;
    logic [`NUM_CLUSTERS-1:0]           cluster_busy;

    logic                               arb_valid;
    mem_req_t                           arb_req;
    logic                               arb_ready;
    logic                               fifo_empty;

    // Clusters always take responses
    assign mem_rsp_ready = 1'b1;

    dcr_regs i_dcr_regs (
        .clk          (clk),
        .reset        (reset),
        .dcr_wr_valid (dcr_wr_valid),
        .dcr_wr       (dcr_wr),
        .cfg          (cfg),
        .start        (start)
    );

    for (genvar i = 0; i < `NUM_CLUSTERS; i++) begin : g_clusters
        compute_cluster #(
            .CLUSTER_ID (i)
        ) i_cluster (
            .clk       (clk),
            .reset     (reset),
            .cfg       (cfg),
            .start     (start),
            .req_valid (cluster_req_valid[i]),
            .req       (cluster_req[i]),
            .req_ready (cluster_req_ready[i]),
            .rsp_valid (cluster_rsp_valid[i]),
            .rsp       (cluster_rsp),
            .busy      (cluster_busy[i])
        );
    end

    mem_arbiter i_arbiter (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (cluster_req_valid),
        .in_req        (cluster_req),
        .in_ready      (cluster_req_ready),
        .out_valid     (arb_valid),
        .out_req       (arb_req),
        .out_ready     (arb_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .rsp_valid     (cluster_rsp_valid),
        .rsp           (cluster_rsp)
    );

    mem_req_fifo #(
        .DEPTH (`MEM_FIFO_DEPTH)
    ) i_req_fifo (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (arb_valid),
        .in_req    (arb_req),
        .in_ready  (arb_ready),
        .out_valid (mem_req_valid),
        .out_req   (mem_req),
        .out_ready (mem_req_ready),
        .empty     (fifo_empty)
    );

    // Pending requests in the FIFO still count as activity
    assign busy = (|cluster_busy) || !fifo_empty;

endmodule

//--- dv/gpu_device_asserts.sv
// Bound checks on the memory request port
// Stall stability, quiet port after reset and busy held until the last write
module gpu_device_asserts import gpu_pkg::*; (
    input logic     clk,
    input logic     reset,
    input logic     mem_req_valid,
    input mem_req_t mem_req,
    input logic     mem_req_ready,
    input logic     busy
);
    timeunit 1ns;
    timeprecision 1ps;

    // Request holds until the memory takes it
    stall_stable: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else $error("memory request changed while stalled");

    reset_quiet: assert property (@(posedge clk) reset |=> !mem_req_valid)
        else $error("mem_req_valid high in the cycle after reset");

    // Busy only drops once the final result write has left the port
    busy_until_last_write: assert property (@(posedge clk) disable iff (reset)
        $fell(busy) |-> $past(mem_req_valid && mem_req_ready && mem_req.rw))
        else $error("busy fell before the last write left the memory port");

endmodule

bind gpu_device gpu_device_asserts i_asserts (
    .clk           (clk),
    .reset         (reset),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_req_ready (mem_req_ready),
    .busy          (busy)
);

//--- dv/gpu_device_tb.sv
// Directed testbench for the GPU device
// Memory model with random stall and delay, reference sums per cluster
`include "gpu_config.svh"

module gpu_device_tb import gpu_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NC = `NUM_CLUSTERS;
    localparam int ID_BITS = $clog2(NC);
    localparam logic [1:0] KIND_RD = 2'b01;
    localparam logic [1:0] KIND_WR = 2'b10;
    // Words per cluster in each run, summed over all clusters
    localparam int TOTAL_WORDS = NC * (8 + 8 + 1 + 6);
    localparam int TIMEOUT_CYCLES = TOTAL_WORDS * 40;

    logic clk;
    logic reset;
    logic mem_req_valid;
    mem_req_t mem_req;
    logic mem_req_ready;
    logic mem_rsp_valid;
    mem_rsp_t mem_rsp;
    logic mem_rsp_ready;
    logic dcr_wr_valid;
    dcr_wr_t dcr_wr;
    logic busy;

    integer seed = 38;
    logic random_mode;
    int cycle;
    logic [31:0] mem [2**16];
    logic [15:0] exp_base;
    logic [15:0] exp_count;
    logic [15:0] exp_stride;
    logic [15:0] exp_result;
    logic [15:0] next_addr [NC];
    int reads_seen [NC];
    int writes_seen [NC];
    mem_rsp_t rsp_q [$];
    int due_q [$];

    gpu_device i_dut (
        .clk           (clk),
        .reset         (reset),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .mem_rsp_ready (mem_rsp_ready),
        .dcr_wr_valid  (dcr_wr_valid),
        .dcr_wr        (dcr_wr),
        .busy          (busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_error(string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_mem_req(string name, mem_req_t actual, mem_req_t expected);
        if (actual !== expected) begin
            report_error($sformatf("MISMATCH %s: got %h expected %h", name, actual, expected));
        end
    endtask

    task automatic check_busy(string name, logic actual, logic expected);
        if (actual !== expected) begin
            report_error($sformatf("MISMATCH %s: got %h expected %h", name, actual, expected));
        end
    endtask

    // Sum of one cluster's block, wrapping at 32 bits
    function automatic logic [31:0] ref_sum(int id);
        logic [31:0] acc;
        logic [15:0] addr;
        acc = '0;
        addr = exp_base + exp_stride * 16'(id);
        for (int k = 0; k < int'(exp_count); k++) begin
            acc = acc + mem[addr];
            addr = addr + 16'd1;
        end
        return acc;
    endfunction

    task automatic check_request(mem_req_t req);
        int id;
        mem_req_t exp;
        exp = '0;
        if (!req.rw) begin
            id = int'(req.tag[ID_BITS-1:0]);
            if (reads_seen[id] >= int'(exp_count)) begin
                report_error($sformatf("cluster %0d issued more than %0d reads", id, exp_count));
            end
            exp.addr = next_addr[id];
            exp.tag = {KIND_RD, ID_BITS'(id)};
            check_mem_req("mem_req", req, exp);
            next_addr[id] = next_addr[id] + 16'd1;
            reads_seen[id]++;
        end else begin
            // Cluster implied by the result address
            id = int'(req.addr - exp_result);
            if (id < 0 || id >= NC) begin
                report_error($sformatf("write to %h is outside the result block", req.addr));
            end
            if (reads_seen[id] != int'(exp_count) || writes_seen[id] != 0) begin
                report_error($sformatf("cluster %0d wrote early or more than once", id));
            end
            exp.rw = 1'b1;
            exp.byteen = '1;
            exp.addr = req.addr;
            exp.data = ref_sum(id);
            exp.tag = {KIND_WR, ID_BITS'(id)};
            check_mem_req("mem_req", req, exp);
            writes_seen[id]++;
        end
    endtask

    // In-order memory with optional stall and response delay
    always @(posedge clk) begin : memory_model
        int delay;
        mem_rsp_t item;
        if (reset) begin
            mem_req_ready <= 1'b0;
            mem_rsp_valid <= 1'b0;
            rsp_q.delete();
            due_q.delete();
            cycle = 0;
        end else begin
            cycle = cycle + 1;
            if (mem_rsp_valid) begin
                check_busy("mem_rsp_ready", mem_rsp_ready, 1'b1);
            end
            if (mem_req_valid && mem_req_ready) begin
                check_request(mem_req);
                if (!mem_req.rw) begin
                    delay = random_mode ? int'($random(seed) & 3) : 0;
                    item.data = mem[mem_req.addr];
                    item.tag = mem_req.tag;
                    rsp_q.push_back(item);
                    due_q.push_back(cycle + delay);
                end
            end
            if (rsp_q.size() != 0 && due_q[0] <= cycle) begin
                mem_rsp_valid <= 1'b1;
                mem_rsp <= rsp_q.pop_front();
                void'(due_q.pop_front());
            end else begin
                mem_rsp_valid <= 1'b0;
            end
            mem_req_ready <= random_mode ? (($random(seed) & 3) != 0) : 1'b1;
        end
    end

    task automatic dcr_write(logic [`DCR_ADDR_WIDTH-1:0] addr, logic [`DCR_DATA_WIDTH-1:0] data);
        @(posedge clk);
        dcr_wr_valid <= 1'b1;
        dcr_wr.addr <= addr;
        dcr_wr.data <= data;
        @(posedge clk);
        dcr_wr_valid <= 1'b0;
    endtask

    task automatic run_reduction(logic [15:0] base, logic [15:0] count, logic [15:0] stride,
                                 logic [15:0] result, bit restart);
        int waited;
        exp_base = base;
        exp_count = count;
        exp_stride = stride;
        exp_result = result;
        for (int id = 0; id < NC; id++) begin
            next_addr[id] = base + stride * 16'(id);
            reads_seen[id] = 0;
            writes_seen[id] = 0;
        end
        dcr_write(`DCR_BASE_ADDR, 32'(base));
        dcr_write(`DCR_COUNT, 32'(count));
        dcr_write(`DCR_RESULT_ADDR, 32'(result));
        dcr_write(`DCR_STRIDE, 32'(stride));
        dcr_write(`DCR_START, 32'd1);
        waited = 0;
        while (!busy) begin
            @(posedge clk);
            waited++;
            if (waited > 4) report_error("busy did not rise after start");
        end
        if (restart) begin
            repeat (3) @(posedge clk);
            dcr_write(`DCR_START, 32'd1);
        end
        waited = 0;
        while (busy) begin
            @(posedge clk);
            waited++;
            if (waited > 40 * NC * int'(count) + 40) report_error("busy did not fall");
        end
        for (int id = 0; id < NC; id++) begin
            if (reads_seen[id] != int'(count) || writes_seen[id] != 1) begin
                report_error($sformatf("cluster %0d made %0d reads and %0d writes",
                                       id, reads_seen[id], writes_seen[id]));
            end
        end
        // Port stays quiet once the run is over
        repeat (5) begin
            @(posedge clk);
            check_busy("busy", busy, 1'b0);
            check_busy("mem_req_valid", mem_req_valid, 1'b0);
        end
    endtask

    task automatic test_idle_after_reset();
        repeat (10) begin
            @(posedge clk);
            check_busy("busy", busy, 1'b0);
            check_busy("mem_req_valid", mem_req_valid, 1'b0);
        end
    endtask

    task automatic test_basic_reduction();
        random_mode = 1'b0;
        run_reduction(16'h0100, 16'd8, 16'h0040, 16'h8000, 1'b0);
    endtask

    task automatic test_random_stall();
        random_mode = 1'b1;
        run_reduction(16'h0100, 16'd8, 16'h0040, 16'h8000, 1'b0);
    endtask

    task automatic test_reconfigure();
        random_mode = 1'b1;
        run_reduction(16'h2000, 16'd1, 16'h0333, 16'h9000, 1'b0);
    endtask

    task automatic test_start_while_busy();
        random_mode = 1'b1;
        run_reduction(16'h4000, 16'd6, 16'h0010, 16'hA000, 1'b1);
    endtask

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        report_error($sformatf("timeout after %0d cycles", TIMEOUT_CYCLES));
    end

    initial begin
        reset = 1'b1;
        dcr_wr_valid = 1'b0;
        dcr_wr = '0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp = '0;
        random_mode = 1'b0;
        cycle = 0;
        for (int a = 0; a < 2**16; a++) begin
            mem[a] = $random(seed);
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        test_idle_after_reset();
        test_basic_reduction();
        test_random_stall();
        test_reconfigure();
        test_start_while_busy();
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+include
hdl/gpu_pkg.sv
hdl/dcr_regs.sv
hdl/compute_cluster.sv
hdl/mem_arbiter.sv
hdl/mem_req_fifo.sv
hdl/gpu_device.sv
dv/gpu_device_asserts.sv
dv/gpu_device_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the GPU device testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    -f verilog.f --top-module gpu_device_tb -o gpu_device_sim \
    && ./obj_dir/gpu_device_sim \
    || { echo "simulation failed" >&2; exit 1; }
